/* Makefile */
TOP := disp_tb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 2>&1 | tee $(LOG)
	@if grep -q '\*\*\* TEST FAILED \*\*\*' $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG)

obj_dir/V$(TOP): disp_top.f $(wildcard design/*.sv test/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f disp_top.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f disp_top.f
	verilator --lint-only --top-module disp_top design/disp_pkg.sv design/disp_regs.sv \
		design/frame_mem.sv design/pixel_fetch.sv design/pixel_fifo.sv design/disp_top.sv

clean:
	rm -rf obj_dir $(LOG)

/* design/disp_pkg.sv */
`default_nettype none

package disp_pkg;

	// Frame memory, 4096 words (a full 640x480 frame would need 38400)
	localparam int MEM_WORDS = 4096;
	localparam int ADDR_W = $clog2(MEM_WORDS);
	localparam int WORD_W = 64;

	// Pixel format
	localparam int PIX_PER_WORD = 8;
	localparam int GRAY_W = WORD_W / PIX_PER_WORD;
	localparam int PIX_W = 3 * GRAY_W; // Gray copied into R, G and B

	// Output FIFO
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

	// AXI4-Lite
	localparam int AXI_ADDR_W = 4;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;

	localparam logic [AXI_ADDR_W-1:0] REG_CTRL = 4'h0; // Bit 0 is enable
	localparam logic [AXI_ADDR_W-1:0] REG_BASE = 4'h4;
	localparam logic [AXI_ADDR_W-1:0] REG_LEN = 4'h8; // Frame length in words
	localparam logic [AXI_ADDR_W-1:0] REG_FRAMES = 4'hc;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Fetch engine states
	typedef enum logic [1:0]
	{
		IDLE,
		READ,
		WAIT,
		EMIT
	} fetch_state_t;

endpackage

`default_nettype wire

/* design/disp_regs.sv */
`default_nettype none

module disp_regs (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [disp_pkg::AXI_ADDR_W-1:0] awaddr,
	input  logic                            awvalid,
	output logic                            awready,
	input  logic [disp_pkg::AXI_DATA_W-1:0] wdata,
	input  logic [disp_pkg::AXI_STRB_W-1:0] wstrb,
	input  logic                            wvalid,
	output logic                            wready,
	output logic [1:0]                      bresp,
	output logic                            bvalid,
	input  logic                            bready,
	input  logic [disp_pkg::AXI_ADDR_W-1:0] araddr,
	input  logic                            arvalid,
	output logic                            arready,
	output logic [disp_pkg::AXI_DATA_W-1:0] rdata,
	output logic [1:0]                      rresp,
	output logic                            rvalid,
	input  logic                            rready,
	output logic                            enable,
	output logic [disp_pkg::ADDR_W-1:0]     base_addr,
	output logic [disp_pkg::ADDR_W:0]       frame_len,
	input  logic                            frame_done
);
	import disp_pkg::*;

	logic ctrl_en;
	logic [ADDR_W-1:0] base_q;
	logic [ADDR_W:0] len_q;
	logic [AXI_DATA_W-1:0] frames_q;
	logic wr_hs;
	logic rd_hs;
	logic [AXI_DATA_W-1:0] aw_cur; // Current value at the write offset
	logic [AXI_DATA_W-1:0] wr_val;
	logic [AXI_DATA_W-1:0] rd_word;

	function automatic logic is_mapped(input logic [AXI_ADDR_W-1:0] a);
		return (a == REG_CTRL) || (a == REG_BASE) || (a == REG_LEN) || (a == REG_FRAMES);
	endfunction

	// Byte lanes without a strobe keep their old value
	function automatic logic [AXI_DATA_W-1:0] strb_merge(
		input logic [AXI_DATA_W-1:0] old_v,
		input logic [AXI_DATA_W-1:0] new_v,
		input logic [AXI_STRB_W-1:0] strb
	);
		logic [AXI_DATA_W-1:0] res;
		res = old_v;
		for (int i = 0; i < AXI_STRB_W; i++)
		begin
			if (strb[i])
				res[i*8 +: 8] = new_v[i*8 +: 8];
		end
		return res;
	endfunction

	assign wr_hs = awvalid & awready & wvalid & wready;
	assign rd_hs = arvalid & arready;

	assign enable = ctrl_en;
	assign base_addr = base_q;
	assign frame_len = len_q;

	always_comb
	begin
		case (awaddr)
			REG_CTRL: aw_cur = AXI_DATA_W'(ctrl_en);
			REG_BASE: aw_cur = AXI_DATA_W'(base_q);
			REG_LEN:  aw_cur = AXI_DATA_W'(len_q);
			default:  aw_cur = '0;
		endcase
		wr_val = strb_merge(aw_cur, wdata, wstrb);
	end

	always_comb
	begin
		case (araddr)
			REG_CTRL:   rd_word = AXI_DATA_W'(ctrl_en);
			REG_BASE:   rd_word = AXI_DATA_W'(base_q);
			REG_LEN:    rd_word = AXI_DATA_W'(len_q);
			REG_FRAMES: rd_word = frames_q;
			default:    rd_word = '0; // Unmapped reads as zero
		endcase
	end

	// Handshake control
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			// Address and data taken together, one-cycle ready pulse
			awready <= awvalid & wvalid & ~awready & ~bvalid;
			wready <= awvalid & wvalid & ~awready & ~bvalid;
			if (wr_hs)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;

			arready <= arvalid & ~arready & ~rvalid;
			if (rd_hs)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// Response payload
	always_ff @(posedge clk)
	begin
		if (wr_hs)
			bresp <= is_mapped(awaddr) ? RESP_OKAY : RESP_SLVERR;
		if (rd_hs)
		begin
			rdata <= rd_word;
			rresp <= is_mapped(araddr) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ctrl_en <= 1'b0;
			base_q <= '0;
			len_q <= '0;
			frames_q <= '0;
		end
		else
		begin
			if (wr_hs)
			begin
				case (awaddr)
					REG_CTRL: ctrl_en <= wr_val[0];
					REG_BASE: base_q <= wr_val[ADDR_W-1:0];
					REG_LEN:  len_q <= wr_val[ADDR_W:0];
					default: ;
				endcase
			end
			// Clear wins over a frame_done in the same cycle
			if (wr_hs && awaddr == REG_FRAMES)
				frames_q <= '0;
			else if (frame_done)
				frames_q <= frames_q + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/disp_top.sv */
`default_nettype none

module disp_top (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [disp_pkg::AXI_ADDR_W-1:0] awaddr,
	input  logic                            awvalid,
	output logic                            awready,
	input  logic [disp_pkg::AXI_DATA_W-1:0] wdata,
	input  logic [disp_pkg::AXI_STRB_W-1:0] wstrb,
	input  logic                            wvalid,
	output logic                            wready,
	output logic [1:0]                      bresp,
	output logic                            bvalid,
	input  logic                            bready,
	input  logic [disp_pkg::AXI_ADDR_W-1:0] araddr,
	input  logic                            arvalid,
	output logic                            arready,
	output logic [disp_pkg::AXI_DATA_W-1:0] rdata,
	output logic [1:0]                      rresp,
	output logic                            rvalid,
	input  logic                            rready,
	input  logic                            mem_we,
	input  logic [disp_pkg::ADDR_W-1:0]     mem_waddr,
	input  logic [disp_pkg::WORD_W-1:0]     mem_wdata,
	output logic                            pix_valid,
	input  logic                            pix_ready,
	output logic [disp_pkg::PIX_W-1:0]      pix_data,
	output logic                            pix_last
);
	import disp_pkg::*;

	logic enable;
	logic [ADDR_W-1:0] base_addr;
	logic [ADDR_W:0] frame_len;
	logic frame_done;
	logic rd_en;
	logic [ADDR_W-1:0] rd_addr;
	logic [WORD_W-1:0] rd_data;
	logic fifo_full;
	logic wr_en;
	logic [PIX_W-1:0] wr_data;
	logic wr_last;

	disp_regs regs_i (
		.clk        (clk),
		.rst        (rst),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.enable     (enable),
		.base_addr  (base_addr),
		.frame_len  (frame_len),
		.frame_done (frame_done)
	);

	// Dual-ported, host and fetch never contend
	frame_mem mem_i (
		.clk       (clk),
		.mem_we    (mem_we),
		.mem_waddr (mem_waddr),
		.mem_wdata (mem_wdata),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	pixel_fetch fetch_i (
		.clk        (clk),
		.rst        (rst),
		.enable     (enable),
		.base_addr  (base_addr),
		.frame_len  (frame_len),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.fifo_full  (fifo_full),
		.wr_en      (wr_en),
		.wr_data    (wr_data),
		.wr_last    (wr_last),
		.frame_done (frame_done)
	);

	pixel_fifo fifo_i (
		.clk       (clk),
		.rst       (rst),
		.wr_en     (wr_en),
		.wr_data   (wr_data),
		.wr_last   (wr_last),
		.full      (fifo_full),
		.pix_valid (pix_valid),
		.pix_ready (pix_ready),
		.pix_data  (pix_data),
		.pix_last  (pix_last)
	);

endmodule

`default_nettype wire

/* design/frame_mem.sv */
`default_nettype none

module frame_mem (
	input  logic                        clk,
	input  logic                        mem_we,
	input  logic [disp_pkg::ADDR_W-1:0] mem_waddr,
	input  logic [disp_pkg::WORD_W-1:0] mem_wdata,
	input  logic                        rd_en,
	input  logic [disp_pkg::ADDR_W-1:0] rd_addr,
	output logic [disp_pkg::WORD_W-1:0] rd_data
);
	import disp_pkg::*;

	logic [WORD_W-1:0] mem [MEM_WORDS];

	// Host write port
	always_ff @(posedge clk)
	begin
		if (mem_we)
			mem[mem_waddr] <= mem_wdata;
	end

	// Registered read, a same-address write still returns the old word
	always_ff @(posedge clk)
	begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* design/pixel_fetch.sv */
`default_nettype none

module pixel_fetch (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        enable,
	input  logic [disp_pkg::ADDR_W-1:0] base_addr,
	input  logic [disp_pkg::ADDR_W:0]   frame_len,
	output logic                        rd_en,
	output logic [disp_pkg::ADDR_W-1:0] rd_addr,
	input  logic [disp_pkg::WORD_W-1:0] rd_data,
	input  logic                        fifo_full,
	output logic                        wr_en,
	output logic [disp_pkg::PIX_W-1:0]  wr_data,
	output logic                        wr_last,
	output logic                        frame_done
);
	import disp_pkg::*;

	fetch_state_t state;
	logic [ADDR_W-1:0] addr_q; // Wraps modulo MEM_WORDS
	logic [ADDR_W:0] word_cnt;
	logic [ADDR_W:0] len_q; // Length latched at frame start
	logic [$clog2(PIX_PER_WORD)-1:0] pix_idx;
	logic [WORD_W-1:0] word_q;
	logic [GRAY_W-1:0] pix_byte;
	logic last_word;
	logic last_pix;

	assign last_word = (word_cnt == len_q - 1'b1);
	assign last_pix = &pix_idx; // Pixel 7

	assign rd_en = (state == READ);
	assign rd_addr = addr_q;

	// Lowest byte first, gray into all three channels
	assign pix_byte = word_q[pix_idx*GRAY_W +: GRAY_W];
	assign wr_data = {3{pix_byte}};

	assign wr_en = (state == EMIT) && !fifo_full; // Stall while full
	assign wr_last = last_word && last_pix;
	assign frame_done = wr_en && wr_last;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			addr_q <= '0;
			word_cnt <= '0;
			len_q <= '0;
			pix_idx <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					// Enable is only sampled between frames
					if (enable && frame_len != '0)
					begin
						addr_q <= base_addr;
						word_cnt <= '0;
						len_q <= frame_len;
						state <= READ;
					end
				end
				READ:
					state <= WAIT;
				WAIT:
				begin
					pix_idx <= '0;
					state <= EMIT;
				end
				EMIT:
				begin
					if (wr_en)
					begin
						pix_idx <= pix_idx + 1'b1;
						if (last_pix)
						begin
							if (last_word)
								state <= IDLE;
							else
							begin
								addr_q <= addr_q + 1'b1;
								word_cnt <= word_cnt + 1'b1;
								state <= READ;
							end
						end
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Word arrives the cycle after rd_en
	always_ff @(posedge clk)
	begin
		if (state == WAIT)
			word_q <= rd_data;
	end

endmodule

`default_nettype wire

/* design/pixel_fifo.sv */
`default_nettype none

module pixel_fifo (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       wr_en,
	input  logic [disp_pkg::PIX_W-1:0] wr_data,
	input  logic                       wr_last,
	output logic                       full,
	output logic                       pix_valid,
	input  logic                       pix_ready,
	output logic [disp_pkg::PIX_W-1:0] pix_data,
	output logic                       pix_last
);
	import disp_pkg::*;

	logic [PIX_W:0] buf_q [FIFO_DEPTH]; // {last, pixel}
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic push;
	logic pop;

	assign full = (count == FIFO_CNT_W'(FIFO_DEPTH));
	assign push = wr_en && !full;
	assign pop = pix_valid && pix_ready;

	// Head entry is the stream, held until popped
	assign pix_valid = (count != '0);
	assign {pix_last, pix_data} = buf_q[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
			buf_q[wr_ptr] <= {wr_last, wr_data};
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

/* disp_top.f */
design/disp_pkg.sv
design/disp_regs.sv
design/frame_mem.sv
design/pixel_fetch.sv
design/pixel_fifo.sv
design/disp_top.sv
test/disp_checker.sv
test/disp_tb.sv

/* test/disp_checker.sv */
`default_nettype none

module disp_checker (
	input logic                       clk,
	input logic                       rst,
	input logic                       bvalid,
	input logic                       bready,
	input logic                       rvalid,
	input logic                       rready,
	input logic                       pix_valid,
	input logic                       pix_ready,
	input logic [disp_pkg::PIX_W-1:0] pix_data,
	input logic                       pix_last,
	input logic                       fifo_full,
	input logic                       wr_en
);
	import disp_pkg::*;

	int fail_cnt = 0;

	// Stream held while the sink stalls
	pix_hold: assert property (@(posedge clk) disable iff (rst)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix_data) && $stable(pix_last))
	else
	begin
		fail_cnt++;
		$error("pix_data or pix_last changed while stalled");
	end

	pix_gray: assert property (@(posedge clk) disable iff (rst)
		pix_valid |-> (pix_data[2*GRAY_W +: GRAY_W] == pix_data[GRAY_W +: GRAY_W])
			&& (pix_data[GRAY_W +: GRAY_W] == pix_data[0 +: GRAY_W]))
	else
	begin
		fail_cnt++;
		$error("RGB channels of pix_data differ");
	end

	b_hold: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
	else
	begin
		fail_cnt++;
		$error("bvalid dropped before bready");
	end

	r_hold: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
	else
	begin
		fail_cnt++;
		$error("rvalid dropped before rready");
	end

	no_push_full: assert property (@(posedge clk) disable iff (rst) fifo_full |-> !wr_en)
	else
	begin
		fail_cnt++;
		$error("FIFO written while full");
	end

endmodule

bind disp_top disp_checker chk_i (
	.clk       (clk),
	.rst       (rst),
	.bvalid    (bvalid),
	.bready    (bready),
	.rvalid    (rvalid),
	.rready    (rready),
	.pix_valid (pix_valid),
	.pix_ready (pix_ready),
	.pix_data  (pix_data),
	.pix_last  (pix_last),
	.fifo_full (fifo_full),
	.wr_en     (wr_en)
);

`default_nettype wire

/* test/disp_tb.sv */
`default_nettype none

module disp_tb;
	import disp_pkg::*;

	localparam int FRAME_LEN = 5; // Words per frame in every run
	localparam int FRAME_PIX = FRAME_LEN * PIX_PER_WORD;
	localparam int TOTAL_PIX = 7 * FRAME_PIX; // 1 + 3 + 2 + 1 frames
	localparam int WATCHDOG_CYCLES = MEM_WORDS + 4 * TOTAL_PIX + 3000;

	logic clk = 1'b0;
	logic rst;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [AXI_DATA_W-1:0] wdata;
	logic [AXI_STRB_W-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [AXI_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic mem_we;
	logic [ADDR_W-1:0] mem_waddr;
	logic [WORD_W-1:0] mem_wdata;
	logic pix_valid;
	logic pix_ready = 1'b0;
	logic [PIX_W-1:0] pix_data;
	logic pix_last;

	logic [WORD_W-1:0] image [MEM_WORDS]; // Copy of the frame memory contents
	logic [PIX_W:0] exp_q [$]; // {last, pixel}
	string test_name = "reset";
	int errors = 0;
	int pix_cnt = 0;
	int frames_run = 0; // Frames the engine was asked to produce
	logic bp_mode = 1'b0;

	disp_top dut_i (.*);

	always #4 clk = ~clk;

	// Random sink about 30% ready under back-pressure
	always @(posedge clk)
		pix_ready <= bp_mode ? (($urandom % 10) < 3) : 1'b1;

	task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp == act)
		else
		begin
			errors++;
			$display("[ERROR] %s: expected %0h, got %0h", name, exp, act);
		end
	endtask

	task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data,
		output logic [1:0] resp);
		@(posedge clk);
		awaddr <= addr;
		wdata <= data;
		wstrb <= '1;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		@(posedge clk);
		while (!awready)
			@(posedge clk);
		expect_eq({test_name, " wready"}, 32'd1, 32'(wready)); // Accepted with the address
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		bready <= 1'b1;
		@(posedge clk);
		while (!bvalid)
			@(posedge clk);
		resp = bresp;
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [AXI_DATA_W-1:0] data,
		output logic [1:0] resp);
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		@(posedge clk);
		while (!arready)
			@(posedge clk);
		arvalid <= 1'b0;
		rready <= 1'b1;
		@(posedge clk);
		while (!rvalid)
			@(posedge clk);
		data = rdata;
		resp = rresp;
		rready <= 1'b0;
	endtask

	// Reference model with byte 0 first and gray copied into all three channels
	task automatic queue_frames(input int base, input int frames);
		logic [WORD_W-1:0] word;
		logic [GRAY_W-1:0] gray;
		logic last;
		for (int f = 0; f < frames; f++)
			for (int w = 0; w < FRAME_LEN; w++)
			begin
				word = image[ADDR_W'(base + w)]; // Wraps at the top of memory
				for (int p = 0; p < PIX_PER_WORD; p++)
				begin
					gray = word[p*GRAY_W +: GRAY_W];
					last = (w == FRAME_LEN - 1) && (p == PIX_PER_WORD - 1);
					exp_q.push_back({last, gray, gray, gray});
				end
			end
	endtask

	task automatic run_frames(input string name, input int base, input int frames);
		int pix_start;
		logic [1:0] resp;
		test_name = name;
		pix_start = pix_cnt;
		frames_run += frames;
		queue_frames(base, frames);
		axi_write(REG_BASE, 32'(base), resp);
		axi_write(REG_LEN, 32'(FRAME_LEN), resp);
		axi_write(REG_CTRL, 32'd1, resp);
		expect_eq({name, " bresp"}, 32'(RESP_OKAY), 32'(resp));
		// Enable dropped ten pixels into the final frame
		while (pix_cnt < pix_start + (frames - 1) * FRAME_PIX + 10)
			@(posedge clk);
		axi_write(REG_CTRL, 32'd0, resp);
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (200)
			@(posedge clk);
		expect_eq({name, " idle"}, 32'd0, 32'(pix_valid));
	endtask

	// Scoreboard
	always @(posedge clk)
	begin
		if (!rst && pix_valid && pix_ready)
		begin
			pix_cnt++;
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("Unexpected pixel %0h in test %s, no pixel was due", pix_data, test_name);
			end
			else
				expect_eq(test_name, 32'(exp_q.pop_front()), 32'({pix_last, pix_data}));
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES)
			@(posedge clk);
		$display("Timeout: test %s did not finish within %0d cycles", test_name, WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		logic [AXI_DATA_W-1:0] data;
		logic [1:0] resp;
		void'($urandom(32'h81c9));
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		mem_we = 1'b0;
		mem_waddr = '0;
		mem_wdata = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			image[i] = {$urandom, $urandom};
		repeat (16)
			@(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < MEM_WORDS; i++)
		begin
			@(posedge clk);
			mem_we <= 1'b1;
			mem_waddr <= ADDR_W'(i);
			mem_wdata <= image[i];
		end
		@(posedge clk);
		mem_we <= 1'b0;

		test_name = "regs";
		axi_write(REG_CTRL, 32'd1, resp); // LEN is still 0 so the engine stays idle
		expect_eq("regs ctrl bresp", 32'(RESP_OKAY), 32'(resp));
		axi_read(REG_CTRL, data, resp);
		expect_eq("regs ctrl", 32'd1, data);
		axi_write(REG_CTRL, 32'd0, resp);
		axi_write(REG_BASE, 32'h0a5, resp);
		axi_read(REG_BASE, data, resp);
		expect_eq("regs base", 32'h0a5, data);
		axi_write(REG_LEN, 32'd7, resp);
		axi_read(REG_LEN, data, resp);
		expect_eq("regs len", 32'd7, data);
		axi_read(4'h2, data, resp);
		expect_eq("regs unmapped rresp", 32'(RESP_SLVERR), 32'(resp));
		expect_eq("regs unmapped rdata", 32'd0, data);

		run_frames("unpack", 'h010, 1);
		run_frames("wrap", MEM_WORDS - 2, 3);
		bp_mode <= 1'b1;
		run_frames("backpressure", 'h100, 2);
		bp_mode <= 1'b0;
		run_frames("disable", 'h200, 1);

		test_name = "frames";
		axi_read(REG_FRAMES, data, resp);
		expect_eq("frames count", 32'(frames_run), data);
		axi_write(REG_FRAMES, 32'd0, resp);
		axi_read(REG_FRAMES, data, resp);
		expect_eq("frames clear", 32'd0, data);

		$display("Closing report: %0d scoreboard errors, %0d checker assertion failures",
			errors, dut_i.chk_i.fail_cnt);
		if (errors == 0 && dut_i.chk_i.fail_cnt == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
